// ==== sim.f ====
+incdir+.
tx_desc_pkg.sv
host_ring_tracker.sv
local_desc_queues.sv
fetch_wb_sequencer.sv
teng_dispatch.sv
tx_desc_ctrl.sv
tb_tx_desc_ctrl.sv

// ==== Bender.yml ====
package:
  name: tx_desc_ctrl

sources:
  - include_dirs:
      - .
    files:
      - tx_desc_pkg.sv
      - host_ring_tracker.sv
      - local_desc_queues.sv
      - fetch_wb_sequencer.sv
      - teng_dispatch.sv
      - tx_desc_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tx_desc_ctrl.sv

// ==== tb_tx_desc_ctrl.sv ====
`timescale 1ns/100ps
`include "tx_desc_consts.svh"

module tb_tx_desc_ctrl;

	// tdlen of 2 gives a ring of 16 descriptors
	localparam int ring_len = 2 << `TXD_RING_UNIT_SHIFT;
	localparam logic [63:0] tdba_base = 64'h0000_0012_3456_7000;
	localparam int wait_limit = 20000;

	logic aclk = 1'b0;
	logic aresetn;
	logic en;
	tx_desc_pkg::host_addr_t tdba;
	logic [12:0] tdlen;
	tx_desc_pkg::host_idx_t tdh;
	logic tdh_set;
	tx_desc_pkg::host_idx_t tdh_fb;
	tx_desc_pkg::host_idx_t tdt;
	logic tdt_set;
	logic dpp;
	logic [5:0] pthresh;
	logic [5:0] hthresh;
	tx_desc_pkg::dword_t idma_m_tdata;
	logic idma_m_tvalid;
	logic idma_m_tlast;
	logic idma_m_tready;
	tx_desc_pkg::dword_t idma_s_tdata;
	logic idma_s_tvalid;
	logic idma_s_tlast;
	logic idma_s_tready;
	tx_desc_pkg::dword_t teng_m_tdata;
	logic teng_m_tvalid;
	logic teng_m_tlast;
	logic teng_m_tready;
	tx_desc_pkg::dword_t teng_s_tdata;
	logic teng_s_tvalid;
	logic teng_s_tlast;
	logic teng_s_tready;

	integer seed = 32'h47c91808;
	int errors = 0;
	int timeouts = 0;

	// Reference model of the host ring and local slots
	int m_tdt = 0;
	int m_curr = 0;
	int fetch_slot = 0;
	int fetched_total = 0;
	int wb_head = 0;
	int wb_slot = 0;
	int wb_seen = 0;
	int done_total = 0;
	int rs_total = 0;
	bit done_q[$];
	tx_desc_pkg::slot_idx_t slot_q[$];
	int dma_resp_q[$];
	int dma_beats = 0;
	int eng_owed = 0;
	logic [31:0] cmd_words [0:2];
	int word_idx = 0;

	// Previous-cycle view of the streams
	logic dma_stalled = 1'b0;
	tx_desc_pkg::dword_t dma_held = '0;
	logic dma_held_last = 1'b0;
	logic eng_stalled = 1'b0;
	tx_desc_pkg::dword_t eng_held = '0;
	logic in_flight = 1'b0;
	logic en_seen = 1'b0;
	tx_desc_pkg::host_idx_t head_prev = '0;

	tx_desc_ctrl dut (
		.aclk, .aresetn, .en, .tdba, .tdlen, .tdh, .tdh_set, .tdh_fb, .tdt, .tdt_set,
		.dpp, .pthresh, .hthresh,
		.idma_m_tdata, .idma_m_tvalid, .idma_m_tlast, .idma_m_tready,
		.idma_s_tdata, .idma_s_tvalid, .idma_s_tlast, .idma_s_tready,
		.teng_m_tdata, .teng_m_tvalid, .teng_m_tlast, .teng_m_tready,
		.teng_s_tdata, .teng_s_tvalid, .teng_s_tlast, .teng_s_tready
	);

	always #4 aclk = ~aclk;

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		errors++;
		$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else report_mismatch(name, expected, actual);
	endtask

	function automatic int expected_fetch_count();
		int fresh;
		int limit;
		int n;
		fresh = (m_tdt + ring_len - m_curr) % ring_len;
		limit = ring_len - m_curr;
		n = (fresh < limit) ? fresh : limit;
		// Free local slots never limit a ring this small
		if (dpp && n > 1)
			n = 1;
		if (n > `TXD_MAX_FETCH)
			n = `TXD_MAX_FETCH;
		return n;
	endfunction

	task automatic check_dma_command();
		logic [63:0] host;
		int n;
		host = {cmd_words[2], cmd_words[1]};
		if (cmd_words[0][31]) begin
			// Completions without RS were dequeued with no write
			while (done_q.size() > 0 && done_q[0] == 1'b0) begin
				void'(done_q.pop_front());
				wb_slot = (wb_slot + 1) % `TXD_DESC_SLOTS;
				wb_head = (wb_head + 1) % ring_len;
			end
			assert (done_q.size() > 0)
			else report_failure("write-back issued with no RS completion waiting");
			if (done_q.size() > 0)
				void'(done_q.pop_front());
			check_value("idma_m_tdata word 0", {1'b1, 3'b000, 12'd1,
				16'((wb_slot << `TXD_DESC_SHIFT) + `TXD_STATUS_OFFSET)}, cmd_words[0]);
			check_value("idma_m_tdata host address",
				tdba_base + 64'((wb_head << `TXD_DESC_SHIFT) + `TXD_STATUS_OFFSET), host);
			wb_slot = (wb_slot + 1) % `TXD_DESC_SLOTS;
			wb_head = (wb_head + 1) % ring_len;
			wb_seen++;
			dma_resp_q.push_back(1);
		end else begin
			n = expected_fetch_count();
			assert (n > 0)
			else report_failure("fetch issued with no fresh descriptor in the ring");
			check_value("idma_m_tdata word 0", {1'b0, 3'b000, 12'(n << `TXD_DESC_SHIFT),
				16'(fetch_slot << `TXD_DESC_SHIFT)}, cmd_words[0]);
			check_value("idma_m_tdata host address",
				tdba_base + 64'(m_curr << `TXD_DESC_SHIFT), host);
			for (int i = 0; i < n; i++)
				slot_q.push_back(tx_desc_pkg::slot_idx_t'(fetch_slot + i));
			fetch_slot = (fetch_slot + n) % `TXD_DESC_SLOTS;
			m_curr = (m_curr + n) % ring_len;
			fetched_total += n;
			dma_resp_q.push_back((n > 0) ? n : 1);
		end
	endtask

	// Collect DMA command words and check each full command
	always @(posedge aclk) begin
		if (aresetn && idma_m_tvalid && idma_m_tready) begin
			cmd_words[word_idx] = idma_m_tdata;
			if (word_idx == 2) begin
				check_dma_command();
				word_idx = 0;
			end else begin
				word_idx = word_idx + 1;
			end
		end
	end

	// Engine commands must follow the fetched slots in order
	always @(posedge aclk) begin
		if (aresetn && teng_m_tvalid && teng_m_tready) begin
			assert (slot_q.size() > 0)
			else report_failure("engine command with no fetched descriptor");
			if (slot_q.size() > 0)
				check_value("teng_m_tdata", {16'h0, 16'(slot_q.pop_front()) << `TXD_DESC_SHIFT},
					teng_m_tdata);
			eng_owed++;
		end
	end

	always @(posedge aclk) begin
		dma_stalled <= idma_m_tvalid && !idma_m_tready;
		dma_held <= idma_m_tdata;
		dma_held_last <= idma_m_tlast;
		eng_stalled <= teng_m_tvalid && !teng_m_tready;
		eng_held <= teng_m_tdata;
		head_prev <= tdh_fb;
		en_seen <= en_seen | en;
		if (teng_m_tvalid && teng_m_tready)
			in_flight <= 1'b1;
		else if (teng_s_tvalid && teng_s_tready && teng_s_tlast)
			in_flight <= 1'b0;
	end

	assert property (@(posedge aclk) disable iff (!aresetn)
		!en_seen |-> !idma_m_tvalid && !idma_s_tready && !teng_m_tvalid && !teng_s_tready)
	else report_failure("stream valid or ready high before enable");

	assert property (@(posedge aclk) disable iff (!aresetn) !en_seen |-> tdh_fb == '0)
	else report_mismatch("tdh_fb", 0, $sampled(tdh_fb));

	assert property (@(posedge aclk) disable iff (!aresetn) dma_stalled |-> idma_m_tvalid)
	else report_failure("idma_m_tvalid dropped before the word transferred");

	assert property (@(posedge aclk) disable iff (!aresetn)
		dma_stalled |-> idma_m_tdata == dma_held)
	else report_mismatch("idma_m_tdata", $sampled(dma_held), $sampled(idma_m_tdata));

	assert property (@(posedge aclk) disable iff (!aresetn)
		dma_stalled |-> idma_m_tlast == dma_held_last)
	else report_mismatch("idma_m_tlast", $sampled(dma_held_last), $sampled(idma_m_tlast));

	assert property (@(posedge aclk) disable iff (!aresetn)
		idma_m_tvalid && idma_m_tready |-> idma_m_tlast == (word_idx == 2))
	else report_mismatch("idma_m_tlast", $sampled(word_idx) == 2, $sampled(idma_m_tlast));

	assert property (@(posedge aclk) disable iff (!aresetn) eng_stalled |-> teng_m_tvalid)
	else report_failure("teng_m_tvalid dropped before the command transferred");

	assert property (@(posedge aclk) disable iff (!aresetn)
		eng_stalled |-> teng_m_tdata == eng_held)
	else report_mismatch("teng_m_tdata", $sampled(eng_held), $sampled(teng_m_tdata));

	assert property (@(posedge aclk) disable iff (!aresetn) teng_m_tvalid |-> teng_m_tlast)
	else report_mismatch("teng_m_tlast", 1, $sampled(teng_m_tlast));

	// One descriptor in flight at the engine
	assert property (@(posedge aclk) disable iff (!aresetn) teng_m_tvalid |-> !in_flight)
	else report_failure("engine command issued before the previous completion");

	assert property (@(posedge aclk) disable iff (!aresetn)
		tdh_fb != head_prev |-> int'(tdh_fb) == (int'(head_prev) + 1) % ring_len)
	else report_mismatch("tdh_fb", (int'($sampled(head_prev)) + 1) % ring_len,
		$sampled(tdh_fb));

	// DMA and engine responders with random stalls
	always begin : responders
		logic dma_hs;
		logic eng_hs;
		logic [31:0] rnd;
		@(posedge aclk);
		dma_hs = idma_s_tvalid && idma_s_tready;
		eng_hs = teng_s_tvalid && teng_s_tready && teng_s_tlast;
		#1;
		rnd = $random(seed);
		idma_m_tready = |rnd[1:0];
		teng_m_tready = |rnd[3:2];
		if (dma_hs) begin
			dma_beats = dma_beats - 1;
			idma_s_tvalid = 1'b0;
			idma_s_tlast = 1'b0;
		end
		if (dma_beats == 0 && dma_resp_q.size() > 0)
			dma_beats = dma_resp_q.pop_front();
		// Random gap before each beat which is then held until taken
		if (dma_beats > 0 && !idma_s_tvalid && rnd[4]) begin
			idma_s_tvalid = 1'b1;
			idma_s_tlast = (dma_beats == 1);
			idma_s_tdata = rnd;
		end
		if (eng_hs) begin
			done_q.push_back(teng_s_tdata[16]);
			done_total++;
			if (teng_s_tdata[16])
				rs_total++;
			eng_owed--;
			teng_s_tvalid = 1'b0;
			teng_s_tlast = 1'b0;
		end
		if (eng_owed > 0 && !teng_s_tvalid && rnd[5]) begin
			teng_s_tvalid = 1'b1;
			teng_s_tlast = 1'b1;
			teng_s_tdata = rnd;
		end
	end

	function automatic bit drained();
		return m_curr == m_tdt && slot_q.size() == 0 && done_total == fetched_total &&
			wb_seen == rs_total && int'(tdh_fb) == fetched_total % ring_len;
	endfunction

	task automatic wait_drained(input string what, output bit ok);
		int cycles;
		cycles = 0;
		while (!drained() && cycles < wait_limit) begin
			@(negedge aclk);
			cycles++;
		end
		ok = drained();
		if (!ok) begin
			timeouts++;
			$display("%0t: timed out waiting for %s to drain", $time, what);
		end
	endtask

	task automatic set_tail(input int value);
		@(posedge aclk);
		#1;
		tdt = tx_desc_pkg::host_idx_t'(value);
		tdt_set = 1'b1;
		m_tdt = value;
		@(posedge aclk);
		#1;
		tdt_set = 1'b0;
	endtask

	initial begin
		bit ok;
		aresetn = 1'b0;
		en = 1'b0;
		tdba = tdba_base;
		tdlen = 13'd2;
		tdh = '0;
		tdh_set = 1'b0;
		tdt = '0;
		tdt_set = 1'b0;
		dpp = 1'b0;
		pthresh = '0;
		hthresh = '0;
		idma_m_tready = 1'b0;
		idma_s_tdata = '0;
		idma_s_tvalid = 1'b0;
		idma_s_tlast = 1'b0;
		teng_m_tready = 1'b0;
		teng_s_tdata = '0;
		teng_s_tvalid = 1'b0;
		teng_s_tlast = 1'b0;
		repeat (8) @(posedge aclk);
		#1;
		aresetn = 1'b1;

		// Idle a few cycles with en low
		repeat (4) @(posedge aclk);
		#1;
		tdh_set = 1'b1;
		tdt = 16'd5;
		tdt_set = 1'b1;
		m_tdt = 5;
		@(posedge aclk);
		#1;
		tdh_set = 1'b0;
		tdt_set = 1'b0;
		en = 1'b1;
		wait_drained("first fetch of five", ok);

		if (ok) begin
			set_tail(12);
			wait_drained("fetch up to index 12", ok);
		end
		// Tail behind current so the fetch stops at the ring end
		if (ok) begin
			set_tail(3);
			wait_drained("wrapped fetch", ok);
		end
		if (ok) begin
			@(posedge aclk);
			#1;
			dpp = 1'b1;
			set_tail(8);
			wait_drained("single descriptor fetches", ok);
		end

		$display("Run complete: %0d errors, %0d timeouts, %0d descriptors, %0d write-backs",
			errors, timeouts, fetched_total, wb_seen);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tx_desc_ctrl.sv ====
`timescale 1ns/100ps

module tx_desc_ctrl (
	input logic aclk,
	input logic aresetn,
	input logic en,
	input tx_desc_pkg::host_addr_t tdba,
	input logic [12:0] tdlen,
	input tx_desc_pkg::host_idx_t tdh,
	input logic tdh_set,
	output tx_desc_pkg::host_idx_t tdh_fb,
	input tx_desc_pkg::host_idx_t tdt,
	input logic tdt_set,
	input logic dpp,
	input logic [5:0] pthresh,
	input logic [5:0] hthresh,
	output tx_desc_pkg::dword_t idma_m_tdata,
	output logic idma_m_tvalid,
	output logic idma_m_tlast,
	input logic idma_m_tready,
	input tx_desc_pkg::dword_t idma_s_tdata,
	input logic idma_s_tvalid,
	input logic idma_s_tlast,
	output logic idma_s_tready,
	output tx_desc_pkg::dword_t teng_m_tdata,
	output logic teng_m_tvalid,
	output logic teng_m_tlast,
	input logic teng_m_tready,
	input tx_desc_pkg::dword_t teng_s_tdata,
	input logic teng_s_tvalid,
	input logic teng_s_tlast,
	output logic teng_s_tready
);

	// Host ring state
	tx_desc_pkg::host_idx_t curr, fresh, limit;
	logic settled, host_dequeue, host_forward;
	tx_desc_pkg::fetch_cnt_t count;

	// Local queue state
	tx_desc_pkg::slot_idx_t in_head, in_tail, out_head;
	tx_desc_pkg::slot_cnt_t in_num, out_num, available, pending;
	logic head_rs, in_enqueue, in_dequeue, out_enqueue, out_dequeue, out_rs;

	host_ring_tracker u_tracker (
		.aclk, .aresetn, .tdlen, .tdh, .tdt, .tdh_set, .tdt_set,
		.host_dequeue, .host_forward, .fwd_count(count),
		.head(tdh_fb), .curr, .fresh, .limit, .settled
	);

	local_desc_queues u_queues (
		.aclk, .aresetn, .in_enqueue, .enq_count(count), .in_dequeue,
		.out_enqueue, .out_rs, .out_dequeue,
		.in_head, .in_tail, .out_head, .in_num, .out_num, .available, .pending, .head_rs
	);

	fetch_wb_sequencer u_sequencer (
		.aclk, .aresetn, .en, .dpp, .pthresh, .hthresh, .tdba,
		.head(tdh_fb), .curr, .fresh, .limit, .settled,
		.in_tail, .out_head, .out_num, .available, .pending, .head_rs,
		.idma_m_tready, .idma_m_tdata, .idma_m_tvalid, .idma_m_tlast,
		.idma_s_tready, .idma_s_tvalid, .idma_s_tlast,
		.host_dequeue, .host_forward, .in_enqueue, .out_dequeue, .count
	);

	// Response payload from the DMA engine carries nothing for this block
	teng_dispatch u_dispatch (
		.aclk, .aresetn, .en, .in_num, .in_head,
		.teng_m_tready, .teng_m_tdata, .teng_m_tvalid, .teng_m_tlast,
		.teng_s_tready, .teng_s_tdata, .teng_s_tvalid, .teng_s_tlast,
		.in_dequeue, .out_enqueue, .out_rs
	);

endmodule

// ==== teng_dispatch.sv ====
`timescale 1ns/100ps
`include "tx_desc_consts.svh"

module teng_dispatch (
	input logic aclk,
	input logic aresetn,
	input logic en,
	input tx_desc_pkg::slot_cnt_t in_num,
	input tx_desc_pkg::slot_idx_t in_head,
	input logic teng_m_tready,
	output tx_desc_pkg::dword_t teng_m_tdata,
	output logic teng_m_tvalid,
	output logic teng_m_tlast,
	output logic teng_s_tready,
	input tx_desc_pkg::dword_t teng_s_tdata,
	input logic teng_s_tvalid,
	input logic teng_s_tlast,
	output logic in_dequeue,
	output logic out_enqueue,
	output logic out_rs
);

	tx_desc_pkg::disp_state_t d, d_next;
	logic done;

	assign done = teng_s_tready && teng_s_tvalid && teng_s_tlast;

	always_comb begin
		d_next = d;
		case (d)
			tx_desc_pkg::disp_idle:
				if (en)
					d_next = tx_desc_pkg::disp_ready;
			tx_desc_pkg::disp_ready:
				if (!en)
					d_next = tx_desc_pkg::disp_idle;
				else if (in_num != '0)
					d_next = tx_desc_pkg::disp_cmd;
			tx_desc_pkg::disp_cmd:
				if (teng_m_tready)
					d_next = tx_desc_pkg::disp_dequeue;
			tx_desc_pkg::disp_dequeue:
				d_next = tx_desc_pkg::disp_ack;
			// Only one descriptor in flight
			tx_desc_pkg::disp_ack:
				if (teng_s_tvalid && teng_s_tlast)
					d_next = tx_desc_pkg::disp_enqueue;
			tx_desc_pkg::disp_enqueue:
				d_next = tx_desc_pkg::disp_ready;
			default:
				d_next = tx_desc_pkg::disp_idle;
		endcase
	end

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			d <= tx_desc_pkg::disp_idle;
			teng_m_tvalid <= 1'b0;
			teng_m_tlast <= 1'b0;
			teng_s_tready <= 1'b0;
			in_dequeue <= 1'b0;
			out_enqueue <= 1'b0;
		end else begin
			d <= d_next;
			teng_m_tvalid <= (d_next == tx_desc_pkg::disp_cmd);
			teng_m_tlast <= (d_next == tx_desc_pkg::disp_cmd);
			teng_s_tready <= (d_next == tx_desc_pkg::disp_ack);
			in_dequeue <= (d_next == tx_desc_pkg::disp_dequeue);
			out_enqueue <= (d_next == tx_desc_pkg::disp_enqueue);
		end
	end

	// Local address of the head slot, RS flag from the completion
	always_ff @(posedge aclk) begin
		if (d_next == tx_desc_pkg::disp_cmd)
			teng_m_tdata <= {16'b0, 16'(in_head) << `TXD_DESC_SHIFT};
		if (done)
			out_rs <= teng_s_tdata[16];
	end

endmodule

// ==== fetch_wb_sequencer.sv ====
`timescale 1ns/100ps
`include "tx_desc_consts.svh"

module fetch_wb_sequencer (
	input logic aclk,
	input logic aresetn,
	input logic en,
	input logic dpp,
	input logic [5:0] pthresh,
	input logic [5:0] hthresh,
	input tx_desc_pkg::host_addr_t tdba,
	input tx_desc_pkg::host_idx_t head,
	input tx_desc_pkg::host_idx_t curr,
	input tx_desc_pkg::host_idx_t fresh,
	input tx_desc_pkg::host_idx_t limit,
	input logic settled,
	input tx_desc_pkg::slot_idx_t in_tail,
	input tx_desc_pkg::slot_idx_t out_head,
	input tx_desc_pkg::slot_cnt_t out_num,
	input tx_desc_pkg::slot_cnt_t available,
	input tx_desc_pkg::slot_cnt_t pending,
	input logic head_rs,
	input logic idma_m_tready,
	output tx_desc_pkg::dword_t idma_m_tdata,
	output logic idma_m_tvalid,
	output logic idma_m_tlast,
	output logic idma_s_tready,
	input logic idma_s_tvalid,
	input logic idma_s_tlast,
	output logic host_dequeue,
	output logic host_forward,
	output logic in_enqueue,
	output logic out_dequeue,
	output tx_desc_pkg::fetch_cnt_t count
);

	tx_desc_pkg::seq_state_t s, s_next;
	tx_desc_pkg::host_addr_t wb_addr;
	tx_desc_pkg::host_addr_t rd_addr;
	tx_desc_pkg::host_idx_t min_lf;
	tx_desc_pkg::host_idx_t min_all;
	tx_desc_pkg::fetch_cnt_t fetch_n;
	logic [15:0] wb_local;
	logic [15:0] rd_local;
	logic [11:0] rd_bytes;
	logic start_fetch;
	logic deq_pulse;
	logic fwd_pulse;

	assign host_dequeue = deq_pulse;
	assign out_dequeue = deq_pulse;
	assign host_forward = fwd_pulse;
	assign in_enqueue = fwd_pulse;

	assign wb_local = (16'(out_head) << `TXD_DESC_SHIFT) + 16'(`TXD_STATUS_OFFSET);
	assign rd_local = 16'(in_tail) << `TXD_DESC_SHIFT;
	assign rd_bytes = 12'(count) << `TXD_DESC_SHIFT;

	always_ff @(posedge aclk) begin
		wb_addr <= tdba + (64'(head) << `TXD_DESC_SHIFT) + 64'(`TXD_STATUS_OFFSET);
		rd_addr <= tdba + (64'(curr) << `TXD_DESC_SHIFT);
	end

	// Smallest of ring limit, fresh and free slots
	always_comb begin
		min_lf = (limit < fresh) ? limit : fresh;
		min_all = (min_lf < 16'(available)) ? min_lf : 16'(available);
		if (dpp && min_all > 16'd1)
			fetch_n = 7'd1;
		else if (min_all > 16'(`TXD_MAX_FETCH))
			fetch_n = 7'(`TXD_MAX_FETCH);
		else
			fetch_n = min_all[6:0];
	end

	assign start_fetch = settled && available != '0 &&
		((!dpp && (pthresh == '0 || pending < 9'(pthresh)) && fresh > 16'(hthresh)) ||
		(pending == '0 && fresh != '0));

	always_comb begin
		s_next = s;
		case (s)
			tx_desc_pkg::seq_idle:
				if (en)
					s_next = tx_desc_pkg::seq_ready;
			tx_desc_pkg::seq_ready:
				if (!en)
					s_next = tx_desc_pkg::seq_idle;
				else if (out_num != '0)
					s_next = head_rs ? tx_desc_pkg::seq_wb_cmd0 : tx_desc_pkg::seq_dequeue;
				else if (start_fetch)
					s_next = tx_desc_pkg::seq_set_size;
			tx_desc_pkg::seq_wb_cmd0:
				if (idma_m_tready)
					s_next = tx_desc_pkg::seq_wb_cmd1;
			tx_desc_pkg::seq_wb_cmd1:
				if (idma_m_tready)
					s_next = tx_desc_pkg::seq_wb_cmd2;
			tx_desc_pkg::seq_wb_cmd2:
				if (idma_m_tready)
					s_next = tx_desc_pkg::seq_wb_ack;
			tx_desc_pkg::seq_wb_ack:
				if (idma_s_tvalid)
					s_next = tx_desc_pkg::seq_dequeue;
			tx_desc_pkg::seq_dequeue:
				s_next = tx_desc_pkg::seq_settle;
			tx_desc_pkg::seq_set_size:
				s_next = tx_desc_pkg::seq_fetch_cmd0;
			tx_desc_pkg::seq_fetch_cmd0:
				if (idma_m_tready)
					s_next = tx_desc_pkg::seq_fetch_cmd1;
			tx_desc_pkg::seq_fetch_cmd1:
				if (idma_m_tready)
					s_next = tx_desc_pkg::seq_fetch_cmd2;
			tx_desc_pkg::seq_fetch_cmd2:
				if (idma_m_tready)
					s_next = tx_desc_pkg::seq_fetch_ack;
			tx_desc_pkg::seq_fetch_ack:
				if (idma_s_tvalid && idma_s_tlast)
					s_next = tx_desc_pkg::seq_enqueue;
			tx_desc_pkg::seq_enqueue:
				s_next = tx_desc_pkg::seq_settle;
			// Wait for the tracker to finish its pointer pipeline
			tx_desc_pkg::seq_settle:
				if (settled)
					s_next = tx_desc_pkg::seq_ready;
			default:
				s_next = tx_desc_pkg::seq_idle;
		endcase
	end

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			s <= tx_desc_pkg::seq_idle;
			idma_m_tvalid <= 1'b0;
			idma_m_tlast <= 1'b0;
			idma_s_tready <= 1'b0;
			deq_pulse <= 1'b0;
			fwd_pulse <= 1'b0;
		end else begin
			s <= s_next;
			idma_m_tvalid <= s_next inside {tx_desc_pkg::seq_wb_cmd0, tx_desc_pkg::seq_wb_cmd1,
				tx_desc_pkg::seq_wb_cmd2, tx_desc_pkg::seq_fetch_cmd0,
				tx_desc_pkg::seq_fetch_cmd1, tx_desc_pkg::seq_fetch_cmd2};
			idma_m_tlast <= s_next inside {tx_desc_pkg::seq_wb_cmd2,
				tx_desc_pkg::seq_fetch_cmd2};
			idma_s_tready <= s_next inside {tx_desc_pkg::seq_wb_ack,
				tx_desc_pkg::seq_fetch_ack};
			deq_pulse <= (s_next == tx_desc_pkg::seq_dequeue);
			fwd_pulse <= (s_next == tx_desc_pkg::seq_enqueue);
		end
	end

	// Command words, bit 31 selects write
	always_ff @(posedge aclk) begin
		case (s_next)
			tx_desc_pkg::seq_wb_cmd0:
				idma_m_tdata <= {1'b1, 3'b0, 12'(`TXD_WB_BYTES), wb_local};
			tx_desc_pkg::seq_wb_cmd1:
				idma_m_tdata <= wb_addr[31:0];
			tx_desc_pkg::seq_wb_cmd2:
				idma_m_tdata <= wb_addr[63:32];
			tx_desc_pkg::seq_set_size:
				count <= fetch_n;
			tx_desc_pkg::seq_fetch_cmd0:
				idma_m_tdata <= {1'b0, 3'b0, rd_bytes, rd_local};
			tx_desc_pkg::seq_fetch_cmd1:
				idma_m_tdata <= rd_addr[31:0];
			tx_desc_pkg::seq_fetch_cmd2:
				idma_m_tdata <= rd_addr[63:32];
			default: ;
		endcase
	end

endmodule

// ==== local_desc_queues.sv ====
`timescale 1ns/100ps
`include "tx_desc_consts.svh"

module local_desc_queues (
	input logic aclk,
	input logic aresetn,
	input logic in_enqueue,
	input tx_desc_pkg::fetch_cnt_t enq_count,
	input logic in_dequeue,
	input logic out_enqueue,
	input logic out_rs,
	input logic out_dequeue,
	output tx_desc_pkg::slot_idx_t in_head,
	output tx_desc_pkg::slot_idx_t in_tail,
	output tx_desc_pkg::slot_idx_t out_head,
	output tx_desc_pkg::slot_cnt_t in_num,
	output tx_desc_pkg::slot_cnt_t out_num,
	output tx_desc_pkg::slot_cnt_t available,
	output tx_desc_pkg::slot_cnt_t pending,
	output logic head_rs
);

	tx_desc_pkg::slot_idx_t out_tail;
	tx_desc_pkg::slot_cnt_t enq_add;
	tx_desc_pkg::slot_cnt_t deq_sub;
	logic rs_mem [0:`TXD_DESC_SLOTS-1];

	assign enq_add = in_enqueue ? tx_desc_pkg::slot_cnt_t'(enq_count) : '0;
	assign deq_sub = tx_desc_pkg::slot_cnt_t'(out_dequeue);

	// Input queue holds fetched descriptors not yet sent to the engine,
	// output queue holds finished ones awaiting write-back
	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			in_head <= '0;
			in_tail <= '0;
			out_head <= '0;
			out_tail <= '0;
			in_num <= '0;
			out_num <= '0;
			pending <= '0;
			available <= tx_desc_pkg::slot_cnt_t'(`TXD_DESC_SLOTS);
		end else begin
			if (in_enqueue)
				in_tail <= in_tail + tx_desc_pkg::slot_idx_t'(enq_count);
			if (in_dequeue)
				in_head <= in_head + 1'b1;
			if (out_enqueue)
				out_tail <= out_tail + 1'b1;
			if (out_dequeue)
				out_head <= out_head + 1'b1;
			in_num <= in_num + enq_add - tx_desc_pkg::slot_cnt_t'(in_dequeue);
			out_num <= out_num + tx_desc_pkg::slot_cnt_t'(out_enqueue) - deq_sub;
			// Slots are occupied from fetch until write-back is done
			pending <= pending + enq_add - deq_sub;
			available <= available - enq_add + deq_sub;
		end
	end

	always_ff @(posedge aclk) begin
		if (out_enqueue)
			rs_mem[out_tail] <= out_rs;
	end

	// Bypass so a just-completed head slot shows its new flag
	always_ff @(posedge aclk) begin
		if (out_enqueue && out_tail == out_head)
			head_rs <= out_rs;
		else
			head_rs <= rs_mem[out_head];
	end

endmodule

// ==== host_ring_tracker.sv ====
`timescale 1ns/100ps
`include "tx_desc_consts.svh"

module host_ring_tracker (
	input logic aclk,
	input logic aresetn,
	input logic [12:0] tdlen,
	input tx_desc_pkg::host_idx_t tdh,
	input tx_desc_pkg::host_idx_t tdt,
	input logic tdh_set,
	input logic tdt_set,
	input logic host_dequeue,
	input logic host_forward,
	input tx_desc_pkg::fetch_cnt_t fwd_count,
	output tx_desc_pkg::host_idx_t head,
	output tx_desc_pkg::host_idx_t curr,
	output tx_desc_pkg::host_idx_t fresh,
	output tx_desc_pkg::host_idx_t limit,
	output logic settled
);

	tx_desc_pkg::host_idx_t ring_len;
	tx_desc_pkg::host_idx_t tail;
	logic strobe;
	logic [4:0] stage;

	// Pipeline temporaries, one extra bit for the wrap
	logic [16:0] head_n0;
	logic [16:0] curr_n0;
	tx_desc_pkg::host_idx_t head_n1;
	tx_desc_pkg::host_idx_t curr_n1;
	logic [16:0] fresh_n0;
	logic [16:0] fresh_n1;
	tx_desc_pkg::host_idx_t fresh_n2;
	tx_desc_pkg::host_idx_t limit_n;

	assign ring_len = tx_desc_pkg::host_idx_t'(tdlen) << `TXD_RING_UNIT_SHIFT;
	assign strobe = tdh_set | tdt_set | host_dequeue | host_forward;

	// Counts are stable once the stage shifter has drained
	assign settled = (stage == '0) && !strobe;

	always_ff @(posedge aclk) begin
		if (tdh_set) begin
			head_n0 <= {1'b0, tdh};
			curr_n0 <= {1'b0, tdh};
		end else begin
			if (host_dequeue)
				head_n0 <= {1'b0, head} + 17'd1;
			if (host_forward)
				curr_n0 <= {1'b0, curr} + 17'(fwd_count);
		end

		if (stage[0]) begin
			head_n1 <= (head_n0 >= {1'b0, ring_len}) ? 16'(head_n0 - {1'b0, ring_len})
				: head_n0[15:0];
			curr_n1 <= (curr_n0 >= {1'b0, ring_len}) ? 16'(curr_n0 - {1'b0, ring_len})
				: curr_n0[15:0];
		end
		if (stage[1])
			fresh_n0 <= {1'b0, tail} + {1'b0, ring_len};
		if (stage[2]) begin
			fresh_n1 <= fresh_n0 - {1'b0, curr};
			limit_n <= ring_len - curr;
		end
		if (stage[3])
			fresh_n2 <= (fresh_n1 >= {1'b0, ring_len}) ? 16'(fresh_n1 - {1'b0, ring_len})
				: fresh_n1[15:0];
	end

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			stage <= '0;
			tail <= '0;
			head <= '0;
			curr <= '0;
			fresh <= '0;
			limit <= '0;
		end else begin
			stage <= {stage[3:0], strobe};
			if (tdt_set)
				tail <= tdt;
			if (stage[1]) begin
				head <= head_n1;
				curr <= curr_n1;
			end
			if (stage[4]) begin
				fresh <= fresh_n2;
				limit <= limit_n;
			end
		end
	end

endmodule

// ==== tx_desc_pkg.sv ====
`include "tx_desc_consts.svh"

package tx_desc_pkg;

	typedef logic [`TXD_HOST_IDX_BITS-1:0] host_idx_t;
	typedef logic [63:0] host_addr_t;
	typedef logic [31:0] dword_t;
	typedef logic [`TXD_SLOT_BITS-1:0] slot_idx_t;
	typedef logic [`TXD_SLOT_BITS:0] slot_cnt_t;
	typedef logic [`TXD_FETCH_CNT_BITS-1:0] fetch_cnt_t;

	// DMA command sequencer
	typedef enum logic [3:0] {
		seq_idle, seq_ready,
		seq_wb_cmd0, seq_wb_cmd1, seq_wb_cmd2, seq_wb_ack,
		seq_dequeue, seq_set_size,
		seq_fetch_cmd0, seq_fetch_cmd1, seq_fetch_cmd2, seq_fetch_ack,
		seq_enqueue, seq_settle
	} seq_state_t;

	// Transmit engine dispatcher
	typedef enum logic [2:0] {
		disp_idle, disp_ready, disp_cmd, disp_dequeue, disp_ack, disp_enqueue
	} disp_state_t;

endpackage

// ==== tx_desc_consts.svh ====
`ifndef TX_DESC_CONSTS_SVH
`define TX_DESC_CONSTS_SVH

// Local descriptor RAM geometry
`define TXD_DESC_SLOTS 256
`define TXD_SLOT_BITS 8

// One descriptor is 16 bytes
`define TXD_DESC_SHIFT 4

// Largest burst the DMA engine accepts, in descriptors
`define TXD_MAX_FETCH 64

// Status byte lives in the last dword of a descriptor
`define TXD_STATUS_OFFSET 12

// tdlen granularity, 8 descriptors per unit
`define TXD_RING_UNIT_SHIFT 3

// Host ring index and fetch count widths
`define TXD_HOST_IDX_BITS 16
`define TXD_FETCH_CNT_BITS 7

// Write-back touches the status byte only
`define TXD_WB_BYTES 1

`endif
